// File: hw/ecc_config.svh
// ------------------------------
// build-time constants for the signing controller
// all arithmetic is mod ECC_PRIME, inputs must already be below it
// ECC_ISSUE_GAP must be at least 2 to cover the program ROM latency
// ------------------------------
`ifndef ECC_CONFIG_SVH
`define ECC_CONFIG_SVH

// operand and register width
`define ECC_WORD_W 16

// 16-bit prime modulus
`define ECC_PRIME 65521

// fixed group generator
`define ECC_GEN 7

// register file holds 2**ECC_RF_ADDR_W words
`define ECC_RF_ADDR_W 3

// program ROM depth is 2**ECC_PROG_ADDR_W
`define ECC_PROG_ADDR_W 5

// cycles between two issued microinstructions
`define ECC_ISSUE_GAP 4

`endif

// File: hw/ecc_pkg.sv
// ------------------------------
// shared types for the signing controller
// mod_add expects both operands below the prime
// ------------------------------
`default_nettype none

`include "ecc_config.svh"

package ecc_pkg;

    // host commands
    typedef enum logic [1:0] {
        CMD_NONE   = 2'd0,
        CMD_KEYGEN = 2'd1,
        CMD_SIGN   = 2'd2
    } cmd_e;

    // microinstruction opcodes
    typedef enum logic [2:0] {
        UOP_NOP     = 3'd0,
        UOP_WR_CORE = 3'd1,
        UOP_RD_CORE = 3'd2,
        UOP_ADD     = 3'd3,
        UOP_MUL     = 3'd4,
        UOP_END     = 3'd5
    } uop_e;

    // host-visible operands moved in and out of the core
    typedef enum logic [2:0] {
        ID_PRIVKEY = 3'd0,
        ID_MSG     = 3'd1,
        ID_NONCE   = 3'd2,
        ID_GEN     = 3'd3,
        ID_PUBKEY  = 3'd4,
        ID_R       = 3'd5,
        ID_S       = 3'd6
    } operand_e;

    typedef struct packed {
        uop_e                      op;
        operand_e                  id;
        logic [`ECC_RF_ADDR_W-1:0] dst;
        logic [`ECC_RF_ADDR_W-1:0] src_a;
        logic [`ECC_RF_ADDR_W-1:0] src_b;
    } uinstr_t;

    // a + b mod P, one conditional subtract
    function automatic logic [`ECC_WORD_W-1:0] mod_add(
        input logic [`ECC_WORD_W-1:0] a,
        input logic [`ECC_WORD_W-1:0] b
    );
        logic [`ECC_WORD_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= (`ECC_WORD_W+1)'(`ECC_PRIME)) begin
            sum = sum - (`ECC_WORD_W+1)'(`ECC_PRIME);
        end
        return sum[`ECC_WORD_W-1:0];
    endfunction

endpackage

`default_nettype wire

// File: hw/ecc_arith_if.sv
// ------------------------------
// link between sequencer, operand path and arithmetic unit
// uop.op is a one-cycle strobe, UOP_NOP between issues
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "ecc_config.svh"

interface ecc_arith_if;
    import ecc_pkg::*;

    // issued microinstruction, fields stay put after the strobe
    uinstr_t                uop;
    // operand into the core on WR_CORE
    logic [`ECC_WORD_W-1:0] wdata;
    // src_a register, read back on RD_CORE
    logic [`ECC_WORD_W-1:0] rdata;
    // multiplier in flight
    logic                   busy;

    modport seq (
        output uop,
        input  busy
    );

    modport operand (
        input  uop,
        input  rdata,
        output wdata
    );

    modport core (
        input  uop,
        input  wdata,
        output rdata,
        output busy
    );

endinterface

`default_nettype wire

// File: hw/ecc_uop_rom.sv
// ------------------------------
// program ROM, one-cycle read latency
// keygen starts at 0, sign at 8, unused words read as END
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "ecc_config.svh"

module ecc_uop_rom (
    input  wire                         clk,
    input  wire [`ECC_PROG_ADDR_W-1:0]  addr_i,
    output ecc_pkg::uinstr_t            instr_o
);
    import ecc_pkg::*;

    function automatic uinstr_t mk(
        input uop_e     op,
        input operand_e id,
        input int       dst,
        input int       src_a,
        input int       src_b
    );
        uinstr_t u;
        u.op    = op;
        u.id    = id;
        u.dst   = dst[`ECC_RF_ADDR_W-1:0];
        u.src_a = src_a[`ECC_RF_ADDR_W-1:0];
        u.src_b = src_b[`ECC_RF_ADDR_W-1:0];
        return u;
    endfunction

    always_ff @(posedge clk) begin
        case (int'(addr_i))
            // keygen: pubkey = privkey * G
            0:       instr_o <= mk(UOP_WR_CORE, ID_PRIVKEY, 0, 0, 0);
            1:       instr_o <= mk(UOP_WR_CORE, ID_GEN,     1, 0, 0);
            2:       instr_o <= mk(UOP_MUL,     ID_PRIVKEY, 2, 0, 1);
            3:       instr_o <= mk(UOP_RD_CORE, ID_PUBKEY,  0, 2, 0);
            4:       instr_o <= mk(UOP_END,     ID_PRIVKEY, 0, 0, 0);
            // sign: r = nonce * G
            8:       instr_o <= mk(UOP_WR_CORE, ID_NONCE,   0, 0, 0);
            9:       instr_o <= mk(UOP_WR_CORE, ID_GEN,     1, 0, 0);
            10:      instr_o <= mk(UOP_MUL,     ID_PRIVKEY, 2, 0, 1);
            11:      instr_o <= mk(UOP_RD_CORE, ID_R,       0, 2, 0);
            // s = msg + r * privkey
            12:      instr_o <= mk(UOP_WR_CORE, ID_PRIVKEY, 3, 0, 0);
            13:      instr_o <= mk(UOP_MUL,     ID_PRIVKEY, 4, 2, 3);
            14:      instr_o <= mk(UOP_WR_CORE, ID_MSG,     5, 0, 0);
            15:      instr_o <= mk(UOP_ADD,     ID_PRIVKEY, 6, 5, 4);
            16:      instr_o <= mk(UOP_RD_CORE, ID_S,       0, 6, 0);
            17:      instr_o <= mk(UOP_END,     ID_PRIVKEY, 0, 0, 0);
            default: instr_o <= mk(UOP_END,     ID_PRIVKEY, 0, 0, 0);
        endcase
    end

endmodule

`default_nettype wire

// File: hw/ecc_modmul.sv
// ------------------------------
// iterative modular multiplier, MSB-first double and add
// a_i must be below the prime, result in ECC_WORD_W+1 cycles
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "ecc_config.svh"

module ecc_modmul (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire                    start_i,
    input  wire [`ECC_WORD_W-1:0]  a_i,
    input  wire [`ECC_WORD_W-1:0]  b_i,
    output logic                   busy_o,
    output logic                   done_o,
    output logic [`ECC_WORD_W-1:0] p_o
);
    import ecc_pkg::*;

    localparam int W     = `ECC_WORD_W;
    localparam int CNT_W = $clog2(W);

    logic [W-1:0]     a_q;
    logic [W-1:0]     b_q;
    logic [W-1:0]     acc;
    logic [W-1:0]     acc_dbl;
    logic [W-1:0]     acc_next;
    logic [CNT_W-1:0] cnt;

    // acc stays reduced after each step
    assign acc_dbl  = mod_add(acc, acc);
    assign acc_next = b_q[W-1] ? mod_add(acc_dbl, a_q) : acc_dbl;
    assign p_o      = acc;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
            cnt    <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy_o <= 1'b1;
                cnt    <= CNT_W'(W - 1);
            end else if (busy_o) begin
                cnt <= cnt - 1'b1;
                if (cnt == '0) begin
                    busy_o <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (start_i) begin
            a_q <= a_i;
            b_q <= b_i;
            acc <= '0;
        end else if (busy_o) begin
            acc <= acc_next;
            b_q <= b_q << 1;
        end
    end

endmodule

`default_nettype wire

// File: hw/ecc_arith_unit.sv
// ------------------------------
// register file, modular adder and multiply write-back
// busy covers the multiply up to its register write
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "ecc_config.svh"

module ecc_arith_unit (
    input  wire       clk,
    input  wire       reset_n,
    ecc_arith_if.core arith
);
    import ecc_pkg::*;

    localparam int W        = `ECC_WORD_W;
    localparam int RF_DEPTH = 2 ** `ECC_RF_ADDR_W;

    logic [W-1:0]                rf [RF_DEPTH];
    logic [W-1:0]                op_a;
    logic [W-1:0]                op_b;
    logic                        mul_start;
    logic                        mul_busy;
    logic                        mul_done;
    logic [W-1:0]                mul_p;
    logic [`ECC_RF_ADDR_W-1:0]   mul_dst;

    assign op_a      = rf[arith.uop.src_a];
    assign op_b      = rf[arith.uop.src_b];
    assign mul_start = (arith.uop.op == UOP_MUL);

    // read-back is combinational from src_a
    assign arith.rdata = op_a;
    assign arith.busy  = mul_busy | mul_done;

    ecc_modmul u_modmul (
        .clk     (clk),
        .reset_n (reset_n),
        .start_i (mul_start),
        .a_i     (op_a),
        .b_i     (op_b),
        .busy_o  (mul_busy),
        .done_o  (mul_done),
        .p_o     (mul_p)
    );

    // ------------------------------
    // register file writes
    // ------------------------------
    always_ff @(posedge clk) begin
        case (arith.uop.op)
            UOP_WR_CORE: rf[arith.uop.dst] <= arith.wdata;
            UOP_ADD:     rf[arith.uop.dst] <= mod_add(op_a, op_b);
            default: begin
            end
        endcase
        // product lands in the destination held since the strobe
        if (mul_done) begin
            rf[mul_dst] <= mul_p;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            mul_dst <= arith.uop.dst;
        end
    end

endmodule

`default_nettype wire

// File: hw/ecc_dsa_fsm.sv
// ------------------------------
// sequencer: command dispatch and microinstruction issue
// one issue every ECC_ISSUE_GAP cycles, frozen while the core is busy
// commands other than KEYGEN and SIGN are not accepted
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "ecc_config.svh"

module ecc_dsa_fsm (
    input  wire            clk,
    input  wire            reset_n,
    input  wire ecc_pkg::cmd_e cmd_i,
    output logic           start_o,
    output logic           ready_o,
    output logic           valid_o,
    ecc_arith_if.seq       arith
);
    import ecc_pkg::*;

    localparam int GAP_W = $clog2(`ECC_ISSUE_GAP + 1);
    localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`ECC_ISSUE_GAP - 1);

    localparam logic [`ECC_PROG_ADDR_W-1:0] KEYGEN_ADDR = `ECC_PROG_ADDR_W'(0);
    localparam logic [`ECC_PROG_ADDR_W-1:0] SIGN_ADDR   = `ECC_PROG_ADDR_W'(8);

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } state_e;

    state_e                       state;
    logic [`ECC_PROG_ADDR_W-1:0]  prog_cntr;
    logic [GAP_W-1:0]             gap_cnt;
    uinstr_t                      instr;

    ecc_uop_rom u_rom (
        .clk     (clk),
        .addr_i  (prog_cntr),
        .instr_o (instr)
    );

    // ------------------------------
    // handshake flags
    // ------------------------------
    assign ready_o = (state == ST_IDLE) && !arith.busy;
    assign start_o = ready_o && ((cmd_i == CMD_KEYGEN) || (cmd_i == CMD_SIGN));

    // ------------------------------
    // program counter and issue
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= ST_IDLE;
            prog_cntr <= KEYGEN_ADDR;
            gap_cnt   <= '0;
            valid_o   <= 1'b0;
            arith.uop <= '0;
        end else begin
            // strobe lasts one cycle
            arith.uop.op <= UOP_NOP;
            case (state)
                ST_IDLE: begin
                    gap_cnt <= '0;
                    if (start_o) begin
                        prog_cntr <= (cmd_i == CMD_SIGN) ? SIGN_ADDR : KEYGEN_ADDR;
                        valid_o   <= 1'b0;
                        state     <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (arith.busy) begin
                        // spacing restarts once the multiply is done
                        gap_cnt <= '0;
                    end else if (gap_cnt != GAP_LAST) begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end else begin
                        gap_cnt <= '0;
                        if (instr.op == UOP_END) begin
                            state   <= ST_IDLE;
                            valid_o <= 1'b1;
                        end else begin
                            arith.uop <= instr;
                            prog_cntr <= prog_cntr + 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/ecc_dsa_ctrl.sv
// ------------------------------
// signing controller top, plain ports
// cmd_i is sampled only while ready_o is high
// privkey_i, msg_i and nonce_i must be below the prime
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "ecc_config.svh"

module ecc_dsa_ctrl (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire [1:0]              cmd_i,
    input  wire [`ECC_WORD_W-1:0]  privkey_i,
    input  wire [`ECC_WORD_W-1:0]  msg_i,
    input  wire [`ECC_WORD_W-1:0]  nonce_i,
    output logic                   ready_o,
    output logic                   valid_o,
    output logic [`ECC_WORD_W-1:0] pubkey_o,
    output logic [`ECC_WORD_W-1:0] r_o,
    output logic [`ECC_WORD_W-1:0] s_o
);
    import ecc_pkg::*;

    localparam logic [`ECC_WORD_W-1:0] GEN = `ECC_WORD_W'(`ECC_GEN);

    logic                   start;
    logic [`ECC_WORD_W-1:0] privkey_q;
    logic [`ECC_WORD_W-1:0] msg_q;
    logic [`ECC_WORD_W-1:0] nonce_q;
    uinstr_t                cur_uop;

    ecc_arith_if u_arith_if ();

    ecc_dsa_fsm u_fsm (
        .clk     (clk),
        .reset_n (reset_n),
        .cmd_i   (cmd_e'(cmd_i)),
        .start_o (start),
        .ready_o (ready_o),
        .valid_o (valid_o),
        .arith   (u_arith_if.seq)
    );

    ecc_arith_unit u_arith (
        .clk     (clk),
        .reset_n (reset_n),
        .arith   (u_arith_if.core)
    );

    assign cur_uop = u_arith_if.uop;

    // ------------------------------
    // input capture on acceptance
    // ------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            privkey_q <= privkey_i;
            msg_q     <= msg_i;
            nonce_q   <= nonce_i;
        end
    end

    // operand mux into the core
    always_comb begin
        u_arith_if.wdata = '0;
        if (cur_uop.op == UOP_WR_CORE) begin
            case (cur_uop.id)
                ID_PRIVKEY: u_arith_if.wdata = privkey_q;
                ID_MSG:     u_arith_if.wdata = msg_q;
                ID_NONCE:   u_arith_if.wdata = nonce_q;
                ID_GEN:     u_arith_if.wdata = GEN;
                default:    u_arith_if.wdata = '0;
            endcase
        end
    end

    // ------------------------------
    // result registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pubkey_o <= '0;
            r_o      <= '0;
            s_o      <= '0;
        end else if (cur_uop.op == UOP_RD_CORE) begin
            case (cur_uop.id)
                ID_PUBKEY: pubkey_o <= u_arith_if.rdata;
                ID_R:      r_o      <= u_arith_if.rdata;
                ID_S:      s_o      <= u_arith_if.rdata;
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tests/ecc_dsa_assert.sv
// ------------------------------
// protocol checks on the controller top, bound into ecc_dsa_ctrl
// in_flight tracks an accepted command until valid_o rises
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "ecc_config.svh"

module ecc_dsa_assert (
    input wire                   clk,
    input wire                   reset_n,
    input wire [1:0]             cmd_i,
    input wire                   ready_o,
    input wire                   valid_o,
    input wire [`ECC_WORD_W-1:0] pubkey_o,
    input wire [`ECC_WORD_W-1:0] r_o,
    input wire [`ECC_WORD_W-1:0] s_o
);
    import ecc_pkg::*;

    logic accept;
    logic in_flight;

    assign accept = ready_o && ((cmd_i == CMD_KEYGEN) || (cmd_i == CMD_SIGN));

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            in_flight <= 1'b0;
        end else if (accept) begin
            in_flight <= 1'b1;
        end else if (valid_o) begin
            in_flight <= 1'b0;
        end
    end

    idle_flags_a: assert property (@(posedge clk) disable iff (!reset_n)
        !in_flight |-> (ready_o || valid_o))
        else $error("ready_o and valid_o both low with no command in flight");

    valid_rise_a: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(valid_o) |-> in_flight)
        else $error("valid_o rose without an accepted command");

    // results only move while a routine runs
    outputs_stable_a: assert property (@(posedge clk) disable iff (!reset_n)
        (ready_o && $past(ready_o)) |-> $stable({pubkey_o, r_o, s_o}))
        else $error("result outputs changed while ready_o was high");

endmodule

`default_nettype wire

// File: tests/tb_ecc_dsa.sv
// ------------------------------
// testbench for the signing controller
// operands are random below the prime, from a fixed seed
// inputs move on the falling edge, results checked once valid_o is high
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "ecc_config.svh"

module tb_ecc_dsa;
    import ecc_pkg::*;

    localparam int W          = `ECC_WORD_W;
    localparam int N_CMDS     = 40;
    localparam int MAX_CYCLES = N_CMDS * 200;
    localparam logic [W-1:0] GEN = W'(`ECC_GEN);

    logic         clk;
    logic         reset_n;
    logic [1:0]   cmd;
    logic [W-1:0] privkey;
    logic [W-1:0] msg;
    logic [W-1:0] nonce;
    wire          ready;
    wire          valid;
    wire  [W-1:0] pubkey;
    wire  [W-1:0] r;
    wire  [W-1:0] s;

    integer       seed = 32'h449261a8;
    int           cycle_cnt = 0;
    int           err_cnt = 0;
    int           test_cnt = 0;
    int           fail_cnt = 0;
    logic [W-1:0] exp_pubkey = '0;
    logic [W-1:0] exp_r = '0;
    logic [W-1:0] exp_s = '0;

    ecc_dsa_ctrl u_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .cmd_i     (cmd),
        .privkey_i (privkey),
        .msg_i     (msg),
        .nonce_i   (nonce),
        .ready_o   (ready),
        .valid_o   (valid),
        .pubkey_o  (pubkey),
        .r_o       (r),
        .s_o       (s)
    );

    bind ecc_dsa_ctrl ecc_dsa_assert u_assert (
        .clk      (clk),
        .reset_n  (reset_n),
        .cmd_i    (cmd_i),
        .ready_o  (ready_o),
        .valid_o  (valid_o),
        .pubkey_o (pubkey_o),
        .r_o      (r_o),
        .s_o      (s_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout, run stopped after %0d cycles", cycle_cnt);
            $display("sim failed");
            $finish;
        end
    end

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic logic [W-1:0] mul_mod(input logic [W-1:0] a, input logic [W-1:0] b);
        longint unsigned prod;
        prod = longint'(a) * longint'(b);
        return W'(prod % longint'(`ECC_PRIME));
    endfunction

    function automatic logic [W-1:0] add_mod(input logic [W-1:0] a, input logic [W-1:0] b);
        longint unsigned sum;
        sum = longint'(a) + longint'(b);
        return W'(sum % longint'(`ECC_PRIME));
    endfunction

    task automatic check_value(input string what, input logic [W-1:0] got,
                               input logic [W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic rand_word(output logic [W-1:0] v);
        logic [31:0] raw;
        raw = $random(seed);
        v = W'(raw % 32'(`ECC_PRIME));
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt != errs_before) begin
            fail_cnt++;
        end
        $display("test %0d %s: %s", test_cnt, name, (err_cnt == errs_before) ? "ok" : "FAILED");
    endtask

    // issue one command, scramble inputs while it runs, then check all results
    task automatic run_cmd(input cmd_e c, input logic [W-1:0] k, input logic [W-1:0] m,
                           input logic [W-1:0] n);
        int errs_before;
        errs_before = err_cnt;
        while (!ready) @(negedge clk);
        cmd     = c;
        privkey = k;
        msg     = m;
        nonce   = n;
        @(negedge clk);
        cmd = CMD_NONE;
        check_value("valid_o after accept", W'(valid), '0);
        check_value("ready_o after accept", W'(ready), '0);
        if (c == CMD_SIGN) begin
            exp_r = mul_mod(n, GEN);
            exp_s = add_mod(m, mul_mod(exp_r, k));
        end else begin
            exp_pubkey = mul_mod(k, GEN);
        end
        while (!valid) begin
            rand_word(privkey);
            rand_word(msg);
            rand_word(nonce);
            cmd = ready ? CMD_NONE : 2'($random(seed));
            @(negedge clk);
        end
        cmd = CMD_NONE;
        check_value("pubkey_o", pubkey, exp_pubkey);
        check_value("r_o", r, exp_r);
        check_value("s_o", s, exp_s);
        check_value("ready_o at done", W'(ready), W'(1));
        report_test((c == CMD_SIGN) ? "sign" : "keygen", errs_before);
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        logic [W-1:0] k;
        logic [W-1:0] m;
        logic [W-1:0] n;
        int           errs_before;
        cmd     = CMD_NONE;
        privkey = '0;
        msg     = '0;
        nonce   = '0;
        reset_n = 1'b0;
        repeat (3) @(negedge clk);
        reset_n = 1'b1;

        errs_before = err_cnt;
        check_value("ready_o after reset", W'(ready), W'(1));
        check_value("valid_o after reset", W'(valid), '0);
        check_value("pubkey_o after reset", pubkey, '0);
        check_value("r_o after reset", r, '0);
        check_value("s_o after reset", s, '0);
        report_test("reset", errs_before);

        for (int i = 0; i < 10; i++) begin
            rand_word(k);
            run_cmd(CMD_KEYGEN, k, '0, '0);
        end
        for (int i = 0; i < 10; i++) begin
            rand_word(k);
            rand_word(m);
            rand_word(n);
            run_cmd(CMD_SIGN, k, m, n);
        end

        // keygen after sign leaves r and s alone
        rand_word(k);
        rand_word(m);
        rand_word(n);
        run_cmd(CMD_SIGN, k, m, n);
        rand_word(k);
        run_cmd(CMD_KEYGEN, k, '0, '0);

        for (int i = 0; i < N_CMDS - 22; i++) begin
            rand_word(k);
            rand_word(m);
            rand_word(n);
            run_cmd(($random(seed) & 1) ? CMD_SIGN : CMD_KEYGEN, k, m, n);
        end

        $display("tests run: %0d, failed: %0d, mismatches: %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hw
hw/ecc_pkg.sv
hw/ecc_arith_if.sv
hw/ecc_uop_rom.sv
hw/ecc_modmul.sv
hw/ecc_arith_unit.sv
hw/ecc_dsa_fsm.sv
hw/ecc_dsa_ctrl.sv
tests/ecc_dsa_assert.sv
tests/tb_ecc_dsa.sv

// File: Makefile
# Verilator build and run for the signing controller testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ecc_dsa
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

SRCS = $(shell grep -v '^+' $(FILELIST))
HDRS = $(wildcard hw/*.svh)
BIN  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)
